/* Makefile */
TOP := tb_lcd_i2c_init

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f rtl/*.sv sim/*.sv
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing --assert -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* rtl/lcd_busy_monitor.sv */
`default_nettype none

module lcd_busy_monitor (
    input  wire logic clk,
    input  wire logic reset_p,
    input  wire logic i_busy,
    output logic      o_busy_rise,
    output logic      o_busy_fall
);

    logic r_sync1;
    logic r_sync2;
    logic r_prev;

    // busy comes from the master's own clock domain logic, so sync it first
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            r_sync1 <= 1'b0;
            r_sync2 <= 1'b0;
            r_prev  <= 1'b0;
        end else begin
            r_sync1 <= i_busy;
            r_sync2 <= r_sync1;
            r_prev  <= r_sync2;
        end
    end

    // edges show up two cycles after i_busy changes
    assign o_busy_rise = r_sync2 & ~r_prev;
    assign o_busy_fall = ~r_sync2 & r_prev;

endmodule

`default_nettype wire

/* rtl/lcd_cmd_pkg.sv */
`default_nettype none

package lcd_cmd_pkg;

    // one expander byte as the sequencer sees it, top bit first
    typedef struct packed {
        logic [3:0] nibble;
        logic       backlight;
        logic       enable;
        logic       rw;
        logic       rs;
    } lcd_frame_s;

    // the master only cares about the raw byte
    typedef union packed {
        logic [7:0] raw;
        lcd_frame_s fields;
    } lcd_frame_u;

    // control bits in the order backlight, enable, rw, rs
    localparam logic [3:0] CTRL_EN_HIGH = 4'b1100;
    localparam logic [3:0] CTRL_EN_LOW  = 4'b1000;

    localparam int NIBBLE_COUNT = 14;

    // each nibble is sent with enable high and then with enable low
    localparam int FRAME_COUNT = 2 * NIBBLE_COUNT;

    // bit 4 of an entry asks for the long wait after its enable-low byte
    // and bits 3:0 hold the nibble itself
    localparam logic [4:0] INIT_NIBBLES [0:NIBBLE_COUNT-1] = '{
        // three wake-up 3s where the first two need the long wait
        5'h13,
        5'h13,
        5'h03,
        // switch to 4-bit mode
        5'h02,
        // function set for two lines
        5'h02,
        5'h08,
        // display off
        5'h00,
        5'h08,
        // clear
        5'h00,
        5'h01,
        // entry mode with increment
        5'h00,
        5'h06,
        // display on with cursor and blink
        5'h00,
        5'h0f
    };

endpackage

`default_nettype wire

/* rtl/lcd_frame_if.sv */
`default_nettype none

interface lcd_frame_if;

    // load is a one-cycle pulse and frame is valid with it
    logic load;
    lcd_cmd_pkg::lcd_frame_u frame;

    // the master has taken the byte
    logic accepted;
    // the master has finished sending it
    logic finished;

    modport seq (
        output load,
        output frame,
        input  accepted,
        input  finished
    );

    modport out (
        input  load,
        input  frame,
        output accepted,
        output finished
    );

endinterface

`default_nettype wire

/* rtl/lcd_frame_output.sv */
`default_nettype none

module lcd_frame_output (
    input  wire logic  clk,
    input  wire logic  reset_p,
    lcd_frame_if.out   frame,
    input  wire logic  i_busy_rise,
    input  wire logic  i_busy_fall,
    output logic [7:0] o_data,
    output logic       o_rw,
    output logic       o_valid
);

    logic                    r_valid;
    logic                    r_in_flight;
    lcd_cmd_pkg::lcd_frame_u r_data;
    logic                    w_accept;
    logic                    w_finish;

    // busy edges with no frame pending or in flight are ignored
    assign w_accept = i_busy_rise & r_valid;
    assign w_finish = i_busy_fall & r_in_flight;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            r_valid     <= 1'b0;
            r_in_flight <= 1'b0;
        end else begin
            if (frame.load) begin
                r_valid <= 1'b1;
            end else if (w_accept) begin
                r_valid     <= 1'b0;
                r_in_flight <= 1'b1;
            end else if (w_finish) begin
                r_in_flight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame.load) begin
            r_data <= frame.frame;
        end
    end

    assign frame.accepted = w_accept;
    assign frame.finished = w_finish;

    assign o_data  = r_data.raw;
    assign o_rw    = r_data.fields.rw;
    assign o_valid = r_valid;

    // the master may sample the byte at any point while valid is up
    a_data_stable: assert property (@(posedge clk) disable iff (reset_p)
        r_valid |=> (!r_valid || $stable(r_data)));

endmodule

`default_nettype wire

/* rtl/lcd_i2c_init.sv */
`default_nettype none

module lcd_i2c_init #(
    parameter int unsigned CYCLES_PER_MS = lcd_timing_pkg::DEFAULT_CYCLES_PER_MS
) (
    input  wire logic  clk,
    input  wire logic  reset_p,
    input  wire logic  i_busy,
    output logic [7:0] o_data,
    output logic       o_rw,
    output logic       o_valid,
    output logic       o_done
);

    logic                                  w_busy_rise;
    logic                                  w_busy_fall;
    logic                                  w_timer_start;
    logic [lcd_timing_pkg::MS_COUNT_W-1:0] w_ms_count;

    lcd_frame_if frame_bus ();

    lcd_busy_monitor u_busy_monitor (
        .clk         (clk),
        .reset_p     (reset_p),
        .i_busy      (i_busy),
        .o_busy_rise (w_busy_rise),
        .o_busy_fall (w_busy_fall)
    );

    lcd_ms_timer #(
        .CYCLES_PER_MS (CYCLES_PER_MS)
    ) u_ms_timer (
        .clk        (clk),
        .reset_p    (reset_p),
        .i_start    (w_timer_start),
        .o_ms_count (w_ms_count)
    );

    lcd_init_sequencer u_sequencer (
        .clk           (clk),
        .reset_p       (reset_p),
        .frame         (frame_bus.seq),
        .o_timer_start (w_timer_start),
        .i_ms_count    (w_ms_count),
        .o_done        (o_done)
    );

    lcd_frame_output u_frame_output (
        .clk         (clk),
        .reset_p     (reset_p),
        .frame       (frame_bus.out),
        .i_busy_rise (w_busy_rise),
        .i_busy_fall (w_busy_fall),
        .o_data      (o_data),
        .o_rw        (o_rw),
        .o_valid     (o_valid)
    );

endmodule

`default_nettype wire

/* rtl/lcd_init_sequencer.sv */
`default_nettype none

module lcd_init_sequencer (
    input  wire logic                                 clk,
    input  wire logic                                 reset_p,
    lcd_frame_if.seq                                  frame,
    output logic                                      o_timer_start,
    input  wire logic [lcd_timing_pkg::MS_COUNT_W-1:0] i_ms_count,
    output logic                                      o_done
);

    localparam int IDX_W = $clog2(lcd_cmd_pkg::FRAME_COUNT);
    localparam logic [IDX_W-1:0] LAST_INDEX = IDX_W'(lcd_cmd_pkg::FRAME_COUNT - 1);

    localparam logic [2:0] PH_POWER_UP = 3'd0;
    localparam logic [2:0] PH_ISSUE    = 3'd1;
    localparam logic [2:0] PH_AWAIT    = 3'd2;
    localparam logic [2:0] PH_DELAY    = 3'd3;
    localparam logic [2:0] PH_DONE     = 3'd4;

    logic [2:0]                            r_phase;
    logic [IDX_W-1:0]                      r_index;
    logic                                  r_load;
    logic                                  r_done;
    lcd_cmd_pkg::lcd_frame_u               r_frame;
    logic [lcd_timing_pkg::MS_COUNT_W-1:0] w_wait_ms;
    logic [IDX_W-1:0]                      w_next_index;
    logic                                  w_last;
    logic                                  w_wait_over;
    logic                                  w_issue;

    // even index sends the nibble with enable high, odd index with enable low
    function automatic lcd_cmd_pkg::lcd_frame_u build_frame(input logic [IDX_W-1:0] idx);
        lcd_cmd_pkg::lcd_frame_u f;
        logic [4:0] entry;
        entry = lcd_cmd_pkg::INIT_NIBBLES[idx[IDX_W-1:1]];
        f.fields.nibble = entry[3:0];
        {f.fields.backlight, f.fields.enable, f.fields.rw, f.fields.rs} =
            idx[0] ? lcd_cmd_pkg::CTRL_EN_LOW : lcd_cmd_pkg::CTRL_EN_HIGH;
        return f;
    endfunction

    // the long wait only follows the enable-low byte of a flagged nibble
    assign w_wait_ms = (lcd_cmd_pkg::INIT_NIBBLES[r_index[IDX_W-1:1]][4] && r_index[0]) ?
                       lcd_timing_pkg::LONG_WAIT_MS : lcd_timing_pkg::SHORT_WAIT_MS;

    assign w_last       = (r_index == LAST_INDEX);
    assign w_wait_over  = (i_ms_count >= w_wait_ms);
    assign w_next_index = (r_phase == PH_POWER_UP) ? '0 : r_index + 1'b1;

    assign w_issue = ((r_phase == PH_POWER_UP) &&
                      (i_ms_count >= lcd_timing_pkg::POWER_UP_MS)) ||
                     ((r_phase == PH_DELAY) && w_wait_over && !w_last);

    // the delay is measured from the end of the I2C transfer
    assign o_timer_start = (r_phase == PH_AWAIT) && frame.finished;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            r_phase <= PH_POWER_UP;
            r_index <= '0;
            r_load  <= 1'b0;
            r_done  <= 1'b0;
        end else begin
            r_load <= w_issue;
            if (w_issue) begin
                r_index <= w_next_index;
            end
            case (r_phase)
                PH_POWER_UP: begin
                    if (w_issue) begin
                        r_phase <= PH_ISSUE;
                    end
                end
                PH_ISSUE: begin
                    if (frame.accepted) begin
                        r_phase <= PH_AWAIT;
                    end
                end
                PH_AWAIT: begin
                    if (frame.finished) begin
                        r_phase <= PH_DELAY;
                    end
                end
                PH_DELAY: begin
                    if (w_wait_over && w_last) begin
                        r_phase <= PH_DONE;
                        r_done  <= 1'b1;
                    end else if (w_issue) begin
                        r_phase <= PH_ISSUE;
                    end
                end
                default: begin
                    r_phase <= PH_DONE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (w_issue) begin
            r_frame <= build_frame(w_next_index);
        end
    end

    assign frame.load  = r_load;
    assign frame.frame = r_frame;
    assign o_done      = r_done;

    a_index_range: assert property (@(posedge clk) disable iff (reset_p)
        r_index < IDX_W'(lcd_cmd_pkg::FRAME_COUNT));

    // nothing more goes to the master once the sequence has ended
    a_no_load_done: assert property (@(posedge clk) disable iff (reset_p)
        (r_phase == PH_DONE) |-> !frame.load);

endmodule

`default_nettype wire

/* rtl/lcd_ms_timer.sv */
`default_nettype none

module lcd_ms_timer #(
    parameter int unsigned CYCLES_PER_MS = lcd_timing_pkg::DEFAULT_CYCLES_PER_MS
) (
    input  wire logic                              clk,
    input  wire logic                              reset_p,
    input  wire logic                              i_start,
    output logic [lcd_timing_pkg::MS_COUNT_W-1:0] o_ms_count
);

    localparam int PRESC_W = (CYCLES_PER_MS > 1) ? $clog2(CYCLES_PER_MS) : 1;
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(CYCLES_PER_MS - 1);

    logic [PRESC_W-1:0]                    r_presc;
    logic [lcd_timing_pkg::MS_COUNT_W-1:0] r_ms_count;
    logic                                  w_tick;

    assign w_tick = (r_presc == PRESC_LAST);

    // start restarts the prescaler too, so every delay begins on a known phase
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            r_presc    <= '0;
            r_ms_count <= '0;
        end else if (i_start) begin
            r_presc    <= '0;
            r_ms_count <= '0;
        end else begin
            if (w_tick) begin
                r_presc <= '0;
            end else begin
                r_presc <= r_presc + 1'b1;
            end
            // hold at the top instead of wrapping
            if (w_tick && r_ms_count != '1) begin
                r_ms_count <= r_ms_count + 1'b1;
            end
        end
    end

    assign o_ms_count = r_ms_count;

    // between starts the count only climbs or holds, so it never wraps
    a_no_wrap: assert property (@(posedge clk) disable iff (reset_p)
        !i_start |=> (r_ms_count >= $past(r_ms_count)));

endmodule

`default_nettype wire

/* rtl/lcd_timing_pkg.sv */
`default_nettype none

package lcd_timing_pkg;

    // width of the elapsed millisecond count
    // the longest wait is 20 ms, so 7 bits leave room before saturation
    localparam int MS_COUNT_W = 7;

    // wait after reset before the first wake-up nibble
    localparam logic [MS_COUNT_W-1:0] POWER_UP_MS = 7'd20;

    // wait after the enable-low byte of the first two wake-up nibbles
    localparam logic [MS_COUNT_W-1:0] LONG_WAIT_MS = 7'd5;

    // wait after every other byte
    localparam logic [MS_COUNT_W-1:0] SHORT_WAIT_MS = 7'd1;

    // clk cycles per millisecond for a 100 MHz clock
    // the top level overrides this through its CYCLES_PER_MS parameter
    localparam int unsigned DEFAULT_CYCLES_PER_MS = 100000;

endpackage

`default_nettype wire

/* sim/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset_p
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // reset is released on a falling edge, away from the active edge
    initial begin
        reset_p = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_p = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/tb_frame_checker.sv */
`default_nettype none

module tb_frame_checker #(
    parameter int CYCLES_PER_MS = 8,
    parameter int POWER_UP_MS   = 20,
    parameter int FRAME_COUNT   = 28
) (
    input  wire logic       clk,
    input  wire logic       reset_p,
    input  wire logic       i_busy,
    input  wire logic [7:0] i_data,
    input  wire logic       i_rw,
    input  wire logic       i_valid,
    input  wire logic       i_done,
    input  wire logic [7:0] i_exp_frames [0:FRAME_COUNT-1],
    input  wire logic [7:0] i_exp_waits [0:FRAME_COUNT-1],
    output logic            o_finished,
    output int              o_error_count
);

    int   errs [1:5];
    logic aborted;

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (errs[num] == 0) ? "ok" : "failed", errs[num]);
    endtask

    task automatic give_up(input int num, input string what);
        $display("timeout: %s", what);
        errs[num] += 1;
        aborted = 1'b1;
    endtask

    // all sampling is on the rising edge, where inputs driven on the falling edge are settled
    initial begin : compare_run
        int         n;
        int         idx;
        int         lo;
        int         bad_tests;
        logic [7:0] held;
        o_finished = 1'b0;
        o_error_count = 0;
        aborted = 1'b0;
        for (n = 1; n <= 5; n++) begin
            errs[n] = 0;
        end
        n = 0;
        @(posedge clk);
        while (reset_p && n < 50) begin
            if (i_valid || i_done) begin
                $display("error: o_valid 0x%h o_done 0x%h in reset, expected 0x0",
                         i_valid, i_done);
                errs[1] += 1;
            end
            @(posedge clk);
            n++;
        end
        if (reset_p) begin
            give_up(1, "reset_p was never released");
        end
        lo = POWER_UP_MS * CYCLES_PER_MS;
        n = 0;
        while (!aborted && !i_valid && n < lo + 20) begin
            @(posedge clk);
            n++;
        end
        if (!aborted && !i_valid) begin
            give_up(1, "no o_valid after the power-up wait");
        end else if (!aborted && (n < lo || n > lo + 4)) begin
            $display("power-up wait was %0d cycles, expected %0d to %0d", n, lo, lo + 4);
            errs[1] += 1;
        end
        report_test(1, "reset and power-up");

        for (idx = 0; idx < FRAME_COUNT && !aborted; idx++) begin
            held = i_data;
            n = 0;
            while (!i_busy && n < 100) begin
                @(posedge clk);
                n++;
                if (!i_valid) begin
                    $display("o_valid fell before i_busy rose at frame %0d", idx);
                    errs[3] += 1;
                end else if (i_data !== held) begin
                    $display("error: o_data 0x%h changed from 0x%h under o_valid", i_data, held);
                    errs[3] += 1;
                end
            end
            if (!i_busy) begin
                give_up(3, "i_busy never rose while o_valid was high");
            end else begin
                if (i_data !== i_exp_frames[idx]) begin
                    $display("error: o_data frame %0d is 0x%h, expected 0x%h",
                             idx, i_data, i_exp_frames[idx]);
                    errs[2] += 1;
                end
                if (i_rw !== 1'b0) begin
                    $display("error: o_rw frame %0d is 0x%h, expected 0x0", idx, i_rw);
                    errs[2] += 1;
                end
                n = 0;
                while (i_valid && n < 3) begin
                    @(posedge clk);
                    n++;
                end
                if (i_valid) begin
                    $display("o_valid still high 3 cycles after i_busy rose at frame %0d", idx);
                    errs[3] += 1;
                end
                n = 0;
                while (i_busy && n < 100) begin
                    @(posedge clk);
                    n++;
                    if (i_valid || i_data !== held) begin
                        $display("error: o_valid 0x%h o_data 0x%h in busy, expected 0x0 and 0x%h",
                                 i_valid, i_data, held);
                        errs[5] += 1;
                    end
                end
                if (i_busy) begin
                    give_up(5, "i_busy stayed high for more than 100 cycles");
                end else begin
                    // gap is counted from the first edge that sees i_busy low
                    lo = int'(i_exp_waits[idx]) * CYCLES_PER_MS;
                    n = 0;
                    while (!i_valid && !i_done && n < lo + 50) begin
                        @(posedge clk);
                        n++;
                    end
                    if (!i_valid && !i_done) begin
                        give_up(4, "neither o_valid nor o_done came after the delay");
                    end else if (n < lo || n > lo + 6) begin
                        $display("delay after frame %0d was %0d cycles, expected %0d to %0d",
                                 idx, n, lo, lo + 6);
                        errs[(idx == FRAME_COUNT - 1) ? 5 : 4] += 1;
                    end
                    if (!aborted && idx == FRAME_COUNT - 1 && (i_valid || !i_done)) begin
                        $display("error: o_done 0x%h o_valid 0x%h after the last frame",
                                 i_done, i_valid);
                        errs[5] += 1;
                    end else if (!aborted && idx < FRAME_COUNT - 1 && i_done) begin
                        $display("o_done rose after frame %0d, before the last frame", idx);
                        errs[5] += 1;
                        aborted = 1'b1;
                    end
                end
            end
        end

        n = 0;
        while (!aborted && n < 200) begin
            @(posedge clk);
            n++;
            if (!i_done || i_valid) begin
                $display({"error: o_done 0x%h o_valid 0x%h after completion, ",
                          "expected 0x1 and 0x0"}, i_done, i_valid);
                errs[5] += 1;
            end
        end
        report_test(2, "frame contents");
        report_test(3, "strobe hold");
        report_test(4, "delays");
        report_test(5, "back-pressure and completion");
        bad_tests = 0;
        for (n = 1; n <= 5; n++) begin
            o_error_count += errs[n];
            if (errs[n] != 0) begin
                bad_tests++;
            end
        end
        $display("counts: 5 tests, %0d passed, %0d failed, %0d errors",
                 5 - bad_tests, bad_tests, o_error_count);
        o_finished = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_lcd_i2c_init.sv */
`default_nettype none

module tb_lcd_i2c_init;

    localparam int CYCLES_PER_MS = 8;
    localparam int FRAME_COUNT   = 28;
    localparam int VALID_LIMIT   = 400;
    localparam int RUN_LIMIT     = 20000;

    // HD44780 power-up nibbles with the three wake-up 3s first and then the 4-bit commands
    localparam logic [3:0] NIBBLES [0:13] = '{
        4'h3, 4'h3, 4'h3, 4'h2, 4'h2, 4'h8, 4'h0,
        4'h8, 4'h0, 4'h1, 4'h0, 4'h6, 4'h0, 4'hf
    };

    logic       clk;
    logic       reset_p;
    logic       busy;
    logic [7:0] lcd_data;
    logic       lcd_rw;
    logic       lcd_valid;
    logic       lcd_done;
    logic       master_error;
    logic       check_finished;
    int         check_errors;
    logic [7:0] exp_frames [0:FRAME_COUNT-1];
    logic [7:0] exp_waits [0:FRAME_COUNT-1];

    // the control bits are backlight, enable, rw and rs
    function automatic logic [7:0] expected_frame(input int index);
        logic [3:0] ctrl;
        // enable drops on the second copy of each nibble
        ctrl = (index % 2 == 0) ? 4'b1100 : 4'b1000;
        return {NIBBLES[index / 2], ctrl};
    endfunction

    // only the enable-low bytes of the first two wake-up nibbles need 5 ms
    function automatic logic [7:0] expected_wait(input int index);
        if (index % 2 == 1 && index < 4) begin
            return 8'd5;
        end
        return 8'd1;
    endfunction

    tb_clock_gen #(
        .PERIOD       (20),
        .RESET_CYCLES (4)
    ) u_clock_gen (
        .clk     (clk),
        .reset_p (reset_p)
    );

    lcd_i2c_init #(
        .CYCLES_PER_MS (CYCLES_PER_MS)
    ) i_dut (
        .clk     (clk),
        .reset_p (reset_p),
        .i_busy  (busy),
        .o_data  (lcd_data),
        .o_rw    (lcd_rw),
        .o_valid (lcd_valid),
        .o_done  (lcd_done)
    );

    tb_frame_checker #(
        .CYCLES_PER_MS (CYCLES_PER_MS),
        .POWER_UP_MS   (20),
        .FRAME_COUNT   (FRAME_COUNT)
    ) u_checker (
        .clk           (clk),
        .reset_p       (reset_p),
        .i_busy        (busy),
        .i_data        (lcd_data),
        .i_rw          (lcd_rw),
        .i_valid       (lcd_valid),
        .i_done        (lcd_done),
        .i_exp_frames  (exp_frames),
        .i_exp_waits   (exp_waits),
        .o_finished    (check_finished),
        .o_error_count (check_errors)
    );

    initial begin : build_reference
        int k;
        for (k = 0; k < FRAME_COUNT; k++) begin
            exp_frames[k] = expected_frame(k);
            exp_waits[k]  = expected_wait(k);
        end
    end

    // single-slot I2C master that takes the byte a few cycles after valid and then stays busy
    initial begin : master_model
        integer seed;
        int     k;
        int     n;
        int     delay;
        int     hold;
        seed = 32'h780ee089;
        busy = 1'b0;
        master_error = 1'b0;
        for (k = 0; k < FRAME_COUNT && !master_error; k++) begin
            n = 0;
            @(negedge clk);
            while (!lcd_valid && n < VALID_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (!lcd_valid) begin
                $display("master model saw no o_valid for frame %0d in %0d cycles", k, n);
                master_error = 1'b1;
            end else begin
                delay = 1 + int'($unsigned($random(seed)) % 5);
                repeat (delay) @(negedge clk);
                busy = 1'b1;
                hold = 3 + int'($unsigned($random(seed)) % 38);
                repeat (hold) @(negedge clk);
                busy = 1'b0;
            end
        end
    end

    initial begin : run_control
        int cycles;
        cycles = 0;
        while (check_finished !== 1'b1 && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (check_finished !== 1'b1) begin
            $display("timeout: the checker did not finish within %0d cycles", RUN_LIMIT);
        end
        if (check_finished === 1'b1 && check_errors == 0 && !master_error) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/lcd_timing_pkg.sv
rtl/lcd_cmd_pkg.sv
rtl/lcd_frame_if.sv
rtl/lcd_busy_monitor.sv
rtl/lcd_ms_timer.sv
rtl/lcd_init_sequencer.sv
rtl/lcd_frame_output.sv
rtl/lcd_i2c_init.sv
sim/tb_clock_gen.sv
sim/tb_frame_checker.sv
sim/tb_lcd_i2c_init.sv
